// ==== tile_pkg.sv ====
package tile_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // word and address widths
   ////////////////////////////////////////////////////////////////////////////

   // one data word and its byte enables
   localparam int DATA_WIDTH      = 32;
   localparam int MASK_WIDTH      = DATA_WIDTH / 8;

   // core side byte address
   localparam int CORE_ADDR_WIDTH = 32;

   // network side word address, byte bits already stripped
   localparam int NET_ADDR_WIDTH  = 14;

   // each of the x and y tile coordinates
   localparam int CORD_WIDTH      = 4;

   ////////////////////////////////////////////////////////////////////////////
   // core address fields
   ////////////////////////////////////////////////////////////////////////////

   // top bit set means the access leaves the tile
   localparam int REMOTE_BIT = 31;

   // destination coordinates of a remote access
   localparam int Y_LSB      = 27;
   localparam int X_LSB      = 23;

   // word address starts above the two byte bits
   localparam int WORD_LSB   = 2;

   // network address bit that marks a control store (freeze register)
   localparam int CTRL_BIT   = 13;

   ////////////////////////////////////////////////////////////////////////////
   // shared types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [DATA_WIDTH-1:0]      data_t;
   typedef logic [MASK_WIDTH-1:0]      mask_t;
   typedef logic [CORE_ADDR_WIDTH-1:0] core_addr_t;
   typedef logic [NET_ADDR_WIDTH-1:0]  net_addr_t;
   typedef logic [CORD_WIDTH-1:0]      cord_t;

   // packet opcode carried on the outbound network
   typedef enum logic
   {
      NET_OP_LOAD  = 1'b0,
      NET_OP_STORE = 1'b1
   } net_op_e;

endpackage

// ==== net_endpoint.sv ====
`timescale 1ns/1ps

module net_endpoint
#(
   parameter int fifo_els_p        = 4,
   parameter int max_out_credits_p = 8
)
(
   input  logic                clk_i,
   input  logic                reset_i,

   // stores arriving from the network
   input  logic                in_v_i,
   input  tile_pkg::net_addr_t in_addr_i,
   input  tile_pkg::data_t     in_data_i,
   input  tile_pkg::mask_t     in_mask_i,
   output logic                in_ready_o,

   // fifo head toward the crossbar, data entries only
   output logic                fifo_v_o,
   output tile_pkg::net_addr_t fifo_addr_o,
   output tile_pkg::data_t     fifo_data_o,
   output tile_pkg::mask_t     fifo_mask_o,
   input  logic                fifo_yumi_i,

   // outbound request and network handshake
   input  logic                out_req_i,
   input  logic                out_ready_i,
   output logic                out_v_o,
   input  logic                credit_return_i,
   output logic                outstanding_stores_o,

   output logic                freeze_o
);

   localparam int ptr_w_lp    = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
   localparam int cnt_w_lp    = $clog2(fifo_els_p + 1);
   localparam int credit_w_lp = $clog2(max_out_credits_p + 1);

   // fifo storage, payload only
   tile_pkg::net_addr_t addr_mem [fifo_els_p];
   tile_pkg::data_t     data_mem [fifo_els_p];
   tile_pkg::mask_t     mask_mem [fifo_els_p];

   logic [ptr_w_lp-1:0]    wr_ptr_r;
   logic [ptr_w_lp-1:0]    rd_ptr_r;
   logic [cnt_w_lp-1:0]    count_r;
   logic                   enq;
   logic                   deq;
   logic                   empty;
   logic                   head_ctrl;
   logic                   ctrl_pop;
   logic                   freeze_r;
   logic [credit_w_lp-1:0] credits_r;
   logic                   launch;

   ////////////////////////////////////////////////////////////////////////////
   // receive fifo
   ////////////////////////////////////////////////////////////////////////////

   assign empty      = (count_r == '0);
   assign in_ready_o = (count_r != cnt_w_lp'(fifo_els_p));
   assign enq        = in_v_i & in_ready_o;

   // head entry is read straight out of the array
   assign fifo_addr_o = addr_mem[rd_ptr_r];
   assign fifo_data_o = data_mem[rd_ptr_r];
   assign fifo_mask_o = mask_mem[rd_ptr_r];

   // control stores never reach memory
   assign head_ctrl = fifo_addr_o[tile_pkg::CTRL_BIT];
   assign ctrl_pop  = ~empty & head_ctrl;
   assign fifo_v_o  = ~empty & ~head_ctrl;
   assign deq       = ctrl_pop | (fifo_v_o & fifo_yumi_i);

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         addr_mem[wr_ptr_r] <= in_addr_i;
         data_mem[wr_ptr_r] <= in_data_i;
         mask_mem[wr_ptr_r] <= in_mask_i;
      end
   end

   // pointers wrap at fifo_els_p, which need not be a power of two
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (enq)
            wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
         if (deq)
            rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
         count_r <= count_r + cnt_w_lp'(enq) - cnt_w_lp'(deq);
      end
   end

   // freeze comes up set; data bit 0 of a control store rewrites it
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_r <= 1'b1;
      else if (ctrl_pop)
         freeze_r <= fifo_data_o[0];
   end

   assign freeze_o = freeze_r;

   ////////////////////////////////////////////////////////////////////////////
   // outbound credits
   ////////////////////////////////////////////////////////////////////////////

   // only offer a packet while a credit is left
   assign out_v_o = out_req_i & (credits_r != '0);
   assign launch  = out_v_o & out_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         credits_r <= credit_w_lp'(max_out_credits_p);
      else
         credits_r <= credits_r - credit_w_lp'(launch) + credit_w_lp'(credit_return_i);
   end

   // anything short of full credit means something is still in flight
   assign outstanding_stores_o = (credits_r != credit_w_lp'(max_out_credits_p));

endmodule

// ==== reservation_tracker.sv ====
`timescale 1ns/1ps

module reservation_tracker
(
   input  logic                clk_i,
   input  logic                reset_i,

   // lr access granted to local memory
   input  logic                set_i,
   input  tile_pkg::net_addr_t set_addr_i,

   // network store accepted by the crossbar
   input  logic                net_store_i,
   input  tile_pkg::net_addr_t net_addr_i,

   output logic                reservation_o
);

   logic                valid_r;
   tile_pkg::net_addr_t addr_r;

   // reserved word address, meaningful only while valid_r is set
   always_ff @(posedge clk_i)
   begin
      if (set_i)
         addr_r <= set_addr_i;
   end

   // a new lr wins over a clearing store in the same cycle
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         valid_r <= 1'b0;
      else if (set_i)
         valid_r <= 1'b1;
      else if (net_store_i && (net_addr_i == addr_r))
         valid_r <= 1'b0;
   end

   assign reservation_o = valid_r;

endmodule

// ==== remote_pkt_encode.sv ====
`timescale 1ns/1ps

module remote_pkt_encode
(
   // core request fields
   input  logic                 core_w_i,
   input  tile_pkg::core_addr_t core_addr_i,
   input  tile_pkg::data_t      core_data_i,
   input  tile_pkg::mask_t      core_mask_i,

   // packet fields toward the network
   output tile_pkg::cord_t      out_x_o,
   output tile_pkg::cord_t      out_y_o,
   output tile_pkg::net_addr_t  out_addr_o,
   output tile_pkg::net_op_e    out_op_o,
   output tile_pkg::data_t      out_data_o,
   output tile_pkg::mask_t      out_mask_o
);

   ////////////////////////////////////////////////////////////////////////////
   // address field split
   ////////////////////////////////////////////////////////////////////////////

   // destination tile sits right under the remote bit
   assign out_y_o = core_addr_i[tile_pkg::Y_LSB +: tile_pkg::CORD_WIDTH];
   assign out_x_o = core_addr_i[tile_pkg::X_LSB +: tile_pkg::CORD_WIDTH];

   // word address, byte offset dropped
   assign out_addr_o = core_addr_i[tile_pkg::WORD_LSB +: tile_pkg::NET_ADDR_WIDTH];

   ////////////////////////////////////////////////////////////////////////////
   // opcode and payload
   ////////////////////////////////////////////////////////////////////////////

   // writes become stores, everything else is a load
   always_comb
   begin
      if (core_w_i)
         out_op_o = tile_pkg::NET_OP_STORE;
      else
         out_op_o = tile_pkg::NET_OP_LOAD;
   end

   // payload rides along untouched
   assign out_data_o = core_data_i;
   assign out_mask_o = core_mask_i;

endmodule

// ==== banked_mem_xbar.sv ====
`timescale 1ns/1ps

module banked_mem_xbar
#(
   parameter int num_banks_p = 2,
   parameter int bank_size_p = 1024
)
(
   input  logic                clk_i,
   input  logic                reset_i,

   // core port, reads and writes
   input  logic                core_v_i,
   input  logic                core_w_i,
   input  tile_pkg::net_addr_t core_addr_i,
   input  tile_pkg::data_t     core_data_i,
   input  tile_pkg::mask_t     core_mask_i,
   output logic                core_yumi_o,
   output logic                core_rv_o,
   output tile_pkg::data_t     core_rdata_o,

   // network port, always a write
   input  logic                net_v_i,
   input  tile_pkg::net_addr_t net_addr_i,
   input  tile_pkg::data_t     net_data_i,
   input  tile_pkg::mask_t     net_mask_i,
   output logic                net_yumi_o
);

   // num_banks_p is a power of two, at least 2
   localparam int bank_w_lp = $clog2(num_banks_p);
   localparam int row_w_lp  = $clog2(bank_size_p);

   logic [bank_w_lp-1:0] core_bank;
   logic [bank_w_lp-1:0] net_bank;
   logic [bank_w_lp-1:0] core_bank_r;
   logic [row_w_lp-1:0]  core_row;
   logic [row_w_lp-1:0]  net_row;
   logic [num_banks_p-1:0] core_grant;
   logic [num_banks_p-1:0] net_grant;
   logic [num_banks_p-1:0][tile_pkg::DATA_WIDTH-1:0] bank_rdata;

   ////////////////////////////////////////////////////////////////////////////
   // address swizzle
   ////////////////////////////////////////////////////////////////////////////

   // low word bits interleave consecutive words across banks
   assign core_bank = core_addr_i[bank_w_lp-1:0];
   assign net_bank  = net_addr_i[bank_w_lp-1:0];

   // what is left above the bank bits picks the row
   assign core_row = core_addr_i[bank_w_lp +: row_w_lp];
   assign net_row  = net_addr_i[bank_w_lp +: row_w_lp];

   ////////////////////////////////////////////////////////////////////////////
   // per bank arbitration and storage
   ////////////////////////////////////////////////////////////////////////////

   for (genvar b = 0; b < num_banks_p; b++)
   begin : g_bank
      logic                core_sel;
      logic                wr_en;
      logic [row_w_lp-1:0] wr_row;
      tile_pkg::data_t     wr_data;
      tile_pkg::mask_t     wr_mask;
      tile_pkg::data_t     rdata_r;
      tile_pkg::data_t     mem [bank_size_p];

      // core first, network only gets an idle bank
      assign core_sel      = core_v_i & (core_bank == bank_w_lp'(b));
      assign core_grant[b] = core_sel;
      assign net_grant[b]  = net_v_i & (net_bank == bank_w_lp'(b)) & ~core_sel;

      // single write port, muxed by the winner
      assign wr_en   = (core_sel & core_w_i) | net_grant[b];
      assign wr_row  = core_sel ? core_row    : net_row;
      assign wr_data = core_sel ? core_data_i : net_data_i;
      assign wr_mask = core_sel ? core_mask_i : net_mask_i;

      always_ff @(posedge clk_i)
      begin
         if (wr_en)
         begin
            for (int i = 0; i < tile_pkg::MASK_WIDTH; i++)
            begin
               if (wr_mask[i])
                  mem[wr_row][8*i +: 8] <= wr_data[8*i +: 8];
            end
         end
         // registered read, only the core reads
         if (core_sel & ~core_w_i)
            rdata_r <= mem[core_row];
      end

      assign bank_rdata[b] = rdata_r;
   end

   assign core_yumi_o = |core_grant;
   assign net_yumi_o  = |net_grant;

   ////////////////////////////////////////////////////////////////////////////
   // read return
   ////////////////////////////////////////////////////////////////////////////

   // remember the bank so the right read register is picked next cycle
   always_ff @(posedge clk_i)
   begin
      core_bank_r <= core_bank;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         core_rv_o <= 1'b0;
      else
         core_rv_o <= core_yumi_o & ~core_w_i;
   end

   assign core_rdata_o = bank_rdata[core_bank_r];

endmodule

// ==== proc_tile.sv ====
`timescale 1ns/1ps

module proc_tile
#(
   parameter int num_banks_p       = 2,
   parameter int bank_size_p       = 1024,
   parameter int fifo_els_p        = 4,
   parameter int max_out_credits_p = 8
)
(
   input  logic                 clk_i,
   input  logic                 reset_i,

   // network in, remote stores
   input  logic                 in_v_i,
   input  tile_pkg::net_addr_t  in_addr_i,
   input  tile_pkg::data_t      in_data_i,
   input  tile_pkg::mask_t      in_mask_i,
   output logic                 in_ready_o,

   // network out, remote requests
   output logic                 out_v_o,
   input  logic                 out_ready_i,
   output tile_pkg::cord_t      out_x_o,
   output tile_pkg::cord_t      out_y_o,
   output tile_pkg::net_addr_t  out_addr_o,
   output tile_pkg::net_op_e    out_op_o,
   output tile_pkg::data_t      out_data_o,
   output tile_pkg::mask_t      out_mask_o,
   input  logic                 credit_return_i,

   // core data memory port
   input  logic                 core_v_i,
   input  logic                 core_w_i,
   input  logic                 core_reserve_i,
   input  tile_pkg::core_addr_t core_addr_i,
   input  tile_pkg::data_t      core_data_i,
   input  tile_pkg::mask_t      core_mask_i,
   output logic                 core_yumi_o,
   output logic                 core_rv_o,
   output tile_pkg::data_t      core_rdata_o,

   output logic                 reservation_o,
   output logic                 outstanding_stores_o,
   output logic                 freeze_o
);

   logic                core_remote;
   logic                local_v;
   logic                remote_req;
   logic                local_yumi;
   logic                launch;
   tile_pkg::net_addr_t core_word_addr;
   logic                fifo_v;
   tile_pkg::net_addr_t fifo_addr;
   tile_pkg::data_t     fifo_data;
   tile_pkg::mask_t     fifo_mask;
   logic                fifo_yumi;

   ////////////////////////////////////////////////////////////////////////////
   // core request split
   ////////////////////////////////////////////////////////////////////////////

   // nothing leaves the core side while frozen
   assign core_remote    = core_addr_i[tile_pkg::REMOTE_BIT];
   assign local_v        = core_v_i & ~core_remote & ~freeze_o;
   assign remote_req     = core_v_i & core_remote & ~freeze_o;
   assign core_word_addr = core_addr_i[tile_pkg::WORD_LSB +: tile_pkg::NET_ADDR_WIDTH];

   // either the local memory or the network takes the request
   assign launch      = out_v_o & out_ready_i;
   assign core_yumi_o = local_yumi | launch;

   net_endpoint #(
      .fifo_els_p        (fifo_els_p),
      .max_out_credits_p (max_out_credits_p)
   ) i_endpoint (
      .clk_i, .reset_i,
      .in_v_i, .in_addr_i, .in_data_i, .in_mask_i, .in_ready_o,
      .fifo_v_o    (fifo_v),
      .fifo_addr_o (fifo_addr),
      .fifo_data_o (fifo_data),
      .fifo_mask_o (fifo_mask),
      .fifo_yumi_i (fifo_yumi),
      .out_req_i   (remote_req),
      .out_ready_i, .out_v_o, .credit_return_i, .outstanding_stores_o, .freeze_o
   );

   // lr reservation, dropped by a network store to the same word
   reservation_tracker i_tracker (
      .clk_i, .reset_i,
      .set_i       (local_yumi & core_reserve_i),
      .set_addr_i  (core_word_addr),
      .net_store_i (fifo_yumi),
      .net_addr_i  (fifo_addr),
      .reservation_o
   );

   remote_pkt_encode i_encode (
      .core_w_i, .core_addr_i, .core_data_i, .core_mask_i,
      .out_x_o, .out_y_o, .out_addr_o, .out_op_o, .out_data_o, .out_mask_o
   );

   banked_mem_xbar #(
      .num_banks_p (num_banks_p),
      .bank_size_p (bank_size_p)
   ) i_xbar (
      .clk_i, .reset_i,
      .core_v_i    (local_v),
      .core_w_i,
      .core_addr_i (core_word_addr),
      .core_data_i, .core_mask_i,
      .core_yumi_o (local_yumi),
      .core_rv_o, .core_rdata_o,
      .net_v_i     (fifo_v),
      .net_addr_i  (fifo_addr),
      .net_data_i  (fifo_data),
      .net_mask_i  (fifo_mask),
      .net_yumi_o  (fifo_yumi)
   );

endmodule

// ==== tb_proc_tile.sv ====
`timescale 1ns/1ps

module tb_proc_tile;

   localparam int max_credits_lp = 8;
   localparam int wait_limit_lp  = 200;
   localparam int read_tries_lp  = 20;
   localparam int seed_lp        = 32'h1fb8_e086;

   logic                        clk_i;
   logic                        reset_i;
   logic                        in_v_i;
   tile_pkg::net_addr_t         in_addr_i;
   tile_pkg::data_t             in_data_i;
   tile_pkg::mask_t             in_mask_i;
   logic                        in_ready_o;
   logic                        out_v_o;
   logic                        out_ready_i;
   tile_pkg::cord_t             out_x_o;
   tile_pkg::cord_t             out_y_o;
   tile_pkg::net_addr_t         out_addr_o;
   tile_pkg::net_op_e           out_op_o;
   tile_pkg::data_t             out_data_o;
   tile_pkg::mask_t             out_mask_o;
   logic                        credit_return_i;
   logic                        core_v_i;
   logic                        core_w_i;
   logic                        core_reserve_i;
   tile_pkg::core_addr_t        core_addr_i;
   tile_pkg::data_t             core_data_i;
   tile_pkg::mask_t             core_mask_i;
   logic                        core_yumi_o;
   logic                        core_rv_o;
   tile_pkg::data_t             core_rdata_o;
   logic                        reservation_o;
   logic                        outstanding_stores_o;
   logic                        freeze_o;

   // reference model state
   tile_pkg::data_t             ref_mem [tile_pkg::net_addr_t];
   int                          ref_credits;
   tile_pkg::net_addr_t         words_a [$];
   tile_pkg::net_addr_t         words_b [$];

   proc_tile #(
      .num_banks_p       (2),
      .bank_size_p       (1024),
      .fifo_els_p        (4),
      .max_out_credits_p (max_credits_lp)
   ) i_dut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference functions
   ////////////////////////////////////////////////////////////////////////////

   // bytes with their enable set take the new data
   function automatic tile_pkg::data_t merge_word(input tile_pkg::data_t old,
         input tile_pkg::data_t wdata, input tile_pkg::mask_t mask);
      tile_pkg::data_t result;
      result = old;
      for (int i = 0; i < 4; i++)
      begin
         if (mask[i])
            result[8*i +: 8] = wdata[8*i +: 8];
      end
      return result;
   endfunction

   // y at 30:27, x at 26:23, word address at 15:2
   function automatic void expect_packet(input tile_pkg::core_addr_t addr, input logic w,
         output tile_pkg::cord_t x, output tile_pkg::cord_t y,
         output tile_pkg::net_addr_t word, output tile_pkg::net_op_e op);
      y    = addr[30:27];
      x    = addr[26:23];
      word = addr[15:2];
      op   = w ? tile_pkg::NET_OP_STORE : tile_pkg::NET_OP_LOAD;
   endfunction

   function automatic tile_pkg::core_addr_t local_addr(input tile_pkg::net_addr_t word);
      return {16'h0000, word, 2'b00};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input tile_pkg::data_t exp,
         input tile_pkg::data_t act);
      if (act !== exp)
         stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_mask(input string name, input tile_pkg::mask_t exp,
         input tile_pkg::mask_t act);
      if (act !== exp)
         stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_cord(input string name, input tile_pkg::cord_t exp,
         input tile_pkg::cord_t act);
      if (act !== exp)
         stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input tile_pkg::net_addr_t exp,
         input tile_pkg::net_addr_t act);
      if (act !== exp)
         stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_op(input string name, input tile_pkg::net_op_e exp,
         input tile_pkg::net_op_e act);
      if (act !== exp)
         stop_on_error($sformatf("MISMATCH %s expected %s actual %s", name, exp.name(),
                                 act.name()));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // drivers
   ////////////////////////////////////////////////////////////////////////////

   task automatic wait_grant(input string name);
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (core_yumi_o !== 1'b1)
      begin
         cycles++;
         if (cycles > wait_limit_lp)
            stop_on_error({name, ": core request was never granted"});
         @(negedge clk_i);
      end
   endtask

   // one core request, held until granted; remote launches are checked at the grant
   task automatic core_access(input string name, input logic w, input logic rsv,
         input tile_pkg::core_addr_t addr, input tile_pkg::data_t wdata,
         input tile_pkg::mask_t mask, output tile_pkg::data_t rdata);
      int                  cycles;
      tile_pkg::cord_t     exp_x;
      tile_pkg::cord_t     exp_y;
      tile_pkg::net_addr_t exp_word;
      tile_pkg::net_op_e   exp_op;
      rdata = '0;
      @(posedge clk_i);
      core_v_i       <= 1'b1;
      core_w_i       <= w;
      core_reserve_i <= rsv;
      core_addr_i    <= addr;
      core_data_i    <= wdata;
      core_mask_i    <= mask;
      wait_grant(name);
      if (addr[31])
      begin
         expect_packet(addr, w, exp_x, exp_y, exp_word, exp_op);
         check_bit({name, " out_v"}, 1'b1, out_v_o);
         check_cord({name, " x"}, exp_x, out_x_o);
         check_cord({name, " y"}, exp_y, out_y_o);
         check_addr({name, " addr"}, exp_word, out_addr_o);
         check_op({name, " op"}, exp_op, out_op_o);
         check_data({name, " data"}, wdata, out_data_o);
         check_mask({name, " mask"}, mask, out_mask_o);
         ref_credits--;
      end
      else if (w)
         ref_mem[addr[15:2]] = merge_word(ref_mem[addr[15:2]], wdata, mask);
      @(posedge clk_i);
      core_v_i       <= 1'b0;
      core_reserve_i <= 1'b0;
      // local read data shows up one cycle after the grant
      if (!w && !addr[31])
      begin
         cycles = 0;
         @(negedge clk_i);
         while (core_rv_o !== 1'b1)
         begin
            cycles++;
            if (cycles > wait_limit_lp)
               stop_on_error({name, ": read data never returned"});
            @(negedge clk_i);
         end
         rdata = core_rdata_o;
      end
   endtask

   // network store latency varies, so reread until the word settles
   task automatic read_check(input string name, input tile_pkg::net_addr_t word);
      tile_pkg::data_t rdata;
      int              tries;
      tries = 0;
      core_access(name, 1'b0, 1'b0, local_addr(word), '0, '0, rdata);
      while ((rdata !== ref_mem[word]) && (tries < read_tries_lp))
      begin
         tries++;
         core_access(name, 1'b0, 1'b0, local_addr(word), '0, '0, rdata);
      end
      check_data(name, ref_mem[word], rdata);
   endtask

   task automatic net_store(input string name, input tile_pkg::net_addr_t addr,
         input tile_pkg::data_t data, input tile_pkg::mask_t mask);
      int cycles;
      @(posedge clk_i);
      in_v_i    <= 1'b1;
      in_addr_i <= addr;
      in_data_i <= data;
      in_mask_i <= mask;
      cycles = 0;
      @(negedge clk_i);
      while (in_ready_o !== 1'b1)
      begin
         cycles++;
         if (cycles > wait_limit_lp)
            stop_on_error({name, ": receive FIFO never had room"});
         @(negedge clk_i);
      end
      @(posedge clk_i);
      in_v_i <= 1'b0;
      // control stores go to the freeze register, not to memory
      if (!addr[13])
         ref_mem[addr] = merge_word(ref_mem[addr], data, mask);
   endtask

   task automatic return_credits(input int n);
      @(posedge clk_i);
      credit_return_i <= 1'b1;
      repeat (n) @(posedge clk_i);
      credit_return_i <= 1'b0;
      ref_credits += n;
   endtask

   task automatic core_traffic(input int ops);
      tile_pkg::net_addr_t word;
      tile_pkg::data_t     wdata;
      tile_pkg::data_t     rdata;
      for (int i = 0; i < ops; i++)
      begin
         word  = words_a[$urandom_range(0, words_a.size() - 1)];
         wdata = $urandom;
         if ($urandom_range(0, 1) == 1)
            core_access("core write", 1'b1, 1'b0, local_addr(word), wdata,
                        tile_pkg::mask_t'($urandom), rdata);
         else
            read_check("core read", word);
      end
   endtask

   task automatic net_traffic(input int ops);
      for (int i = 0; i < ops; i++)
         net_store("net store", words_b[$urandom_range(0, words_b.size() - 1)], $urandom,
                   tile_pkg::mask_t'($urandom));
   endtask

   // request waits with no credit left, then one returned credit lets it go
   task automatic blocked_launch(input string name);
      tile_pkg::core_addr_t addr;
      tile_pkg::data_t      rdata;
      logic                 w;
      addr     = tile_pkg::core_addr_t'($urandom);
      addr[31] = 1'b1;
      w        = 1'($urandom);
      fork
         core_access(name, w, 1'b0, addr, $urandom, tile_pkg::mask_t'($urandom), rdata);
         begin
            // request is driven at this edge
            @(posedge clk_i);
            repeat (3)
            begin
               @(negedge clk_i);
               check_bit({name, " out_v with no credit"}, 1'b0, out_v_o);
            end
            return_credits(1);
         end
      join
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      tile_pkg::data_t      rdata;
      tile_pkg::core_addr_t addr;
      tile_pkg::net_addr_t  lr_word;
      int                   cycles;
      void'($urandom(seed_lp));
      ref_credits     = max_credits_lp;
      reset_i         <= 1'b1;
      in_v_i          <= 1'b0;
      in_addr_i       <= '0;
      in_data_i       <= '0;
      in_mask_i       <= '0;
      out_ready_i     <= 1'b1;
      credit_return_i <= 1'b0;
      core_v_i        <= 1'b0;
      core_w_i        <= 1'b0;
      core_reserve_i  <= 1'b0;
      core_addr_i     <= '0;
      core_data_i     <= '0;
      core_mask_i     <= '0;
      repeat (4) @(posedge clk_i);
      reset_i <= 1'b0;
      @(negedge clk_i);

      // tile comes out of reset frozen
      check_bit("reset freeze", 1'b1, freeze_o);
      check_bit("reset in_ready", 1'b1, in_ready_o);
      check_bit("reset out_v", 1'b0, out_v_o);
      check_bit("reset core_rv", 1'b0, core_rv_o);
      check_bit("reset reservation", 1'b0, reservation_o);
      check_bit("reset outstanding", 1'b0, outstanding_stores_o);
      @(posedge clk_i);
      core_v_i    <= 1'b1;
      core_addr_i <= 32'h0000_0010;
      repeat (3)
      begin
         @(negedge clk_i);
         check_bit("frozen local yumi", 1'b0, core_yumi_o);
      end
      @(posedge clk_i);
      core_addr_i <= 32'h8000_0010;
      repeat (3)
      begin
         @(negedge clk_i);
         check_bit("frozen remote yumi", 1'b0, core_yumi_o);
         check_bit("frozen remote out_v", 1'b0, out_v_o);
      end
      @(posedge clk_i);
      core_v_i <= 1'b0;
      net_store("unfreeze", 14'h2000, 32'h0000_0000, 4'hf);
      cycles = 0;
      @(negedge clk_i);
      while (freeze_o !== 1'b0)
      begin
         cycles++;
         if (cycles > wait_limit_lp)
            stop_on_error("freeze did not clear after the control store");
         @(negedge clk_i);
      end

      // random masked network stores over core-written words
      for (int i = 0; i < 12; i++)
         words_a.push_back(tile_pkg::net_addr_t'($urandom_range(0, 2047)));
      foreach (words_a[i])
         core_access("init write", 1'b1, 1'b0, local_addr(words_a[i]), $urandom, 4'hf, rdata);
      for (int i = 0; i < 40; i++)
         net_store("masked store", words_a[$urandom_range(0, 11)], $urandom,
                   tile_pkg::mask_t'($urandom));
      foreach (words_a[i])
         read_check("merged word", words_a[i]);

      // core and network at once, split rows, banks collide freely
      words_a.delete();
      for (int i = 0; i < 8; i++)
      begin
         words_a.push_back(tile_pkg::net_addr_t'($urandom_range(0, 1023)));
         words_b.push_back(tile_pkg::net_addr_t'($urandom_range(1024, 2047)));
      end
      foreach (words_a[i])
         core_access("init write", 1'b1, 1'b0, local_addr(words_a[i]), $urandom, 4'hf, rdata);
      foreach (words_b[i])
         net_store("init store", words_b[i], $urandom, 4'hf);
      fork
         core_traffic(32);
         net_traffic(32);
      join
      foreach (words_a[i])
         read_check("core word", words_a[i]);
      foreach (words_b[i])
         read_check("net word", words_b[i]);

      // remote requests use up every credit
      for (int i = 0; i < max_credits_lp; i++)
      begin
         addr     = tile_pkg::core_addr_t'($urandom);
         addr[31] = 1'b1;
         core_access("remote launch", 1'($urandom), 1'b0, addr, $urandom,
                     tile_pkg::mask_t'($urandom), rdata);
         @(negedge clk_i);
         check_bit("outstanding", ref_credits != max_credits_lp, outstanding_stores_o);
      end
      blocked_launch("credit return launch");
      blocked_launch("second credit launch");
      return_credits(max_credits_lp);
      @(negedge clk_i);
      check_bit("all credits back", ref_credits != max_credits_lp, outstanding_stores_o);

      // lr reservation and its clearing store
      lr_word = tile_pkg::net_addr_t'($urandom_range(0, 2047));
      core_access("lr", 1'b0, 1'b1, local_addr(lr_word), '0, '0, rdata);
      check_bit("reservation after lr", 1'b1, reservation_o);
      net_store("other store", lr_word ^ 14'h0001, $urandom, 4'hf);
      read_check("other word", lr_word ^ 14'h0001);
      check_bit("reservation after other store", 1'b1, reservation_o);
      net_store("reserved store", lr_word, $urandom, 4'hf);
      read_check("reserved word", lr_word);
      check_bit("reservation after matching store", 1'b0, reservation_o);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== project.f ====
tile_pkg.sv
net_endpoint.sv
reservation_tracker.sv
remote_pkt_encode.sv
banked_mem_xbar.sv
proc_tile.sv
tb_proc_tile.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the proc_tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_proc_tile -o tb_proc_tile \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_proc_tile > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi
exit 0
